//--- verilog/chanlink_frame_pkg.sv
package chanlink_frame_pkg;

	////////////////////
	// frame sequencing

	// one state per kind of frame word
	typedef enum logic [2:0] {
		frm_idle,
		frm_data,
		frm_crc,
		frm_marker,
		frm_status,
		frm_last
	} frm_state_e;

	// fixed trailer words
	localparam logic [15:0] TRL_MARKER = 16'h700C;
	localparam logic [15:0] TRL_END    = 16'h7FFF;

	// crc-15 step over one 13-bit sample
	function automatic logic [14:0] crc15_d13(input logic [12:0] d, input logic [14:0] c);
		logic [14:0] n;
		n[0] = d[0] ^ c[2];
		// middle bits share one pattern
		for (int i = 1; i <= 12; i++) begin
			n[i] = d[i-1] ^ d[i] ^ c[i+1] ^ c[i+2];
		end
		n[13] = d[12] ^ c[14] ^ c[0];
		n[14] = c[1];
		return n;
	endfunction

endpackage

//--- verilog/chanlink_reg_pkg.sv
package chanlink_reg_pkg;

	// register map
	localparam logic [7:0] ADDR_CTRL     = 8'h00;
	localparam logic [7:0] ADDR_STATUS   = 8'h04;
	localparam logic [7:0] ADDR_OVFL_CLR = 8'h08;

	// ctrl bits
	localparam int CTRL_EN_BIT   = 0;
	localparam int CTRL_WARN_BIT = 1;

	// status fields, counts are five bits wide
	localparam int STAT_L1A_LSB  = 0;
	localparam int STAT_EVT_LSB  = 8;
	localparam int STAT_CNT_W    = 5;
	localparam int STAT_OVFL_BIT = 16;

	// decoded bus operation
	typedef enum logic [2:0] {
		op_none,
		op_wr_ctrl,
		op_rd_ctrl,
		op_rd_status,
		op_clr_ovfl,
		op_bad
	} reg_op_e;

endpackage

//--- verilog/chanlink_cfg_decode.sv
module chanlink_cfg_decode #(
	parameter int EVT_DEPTH_LOG2 = 6,
	parameter int L1A_DEPTH_LOG2 = 4
) (
	input  logic                      RCLK,
	input  logic                      RST_RESYNC,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [7:0]                paddr,
	input  logic [31:0]               pwdata,
	input  logic [L1A_DEPTH_LOG2:0]   l1a_count,
	input  logic [EVT_DEPTH_LOG2:0]   evt_count,
	input  logic                      evt_ovfl,
	output logic [31:0]               prdata,
	output logic                      pslverr,
	output logic                      rd_enable,
	output logic                      warn
);

	chanlink_reg_pkg::reg_op_e op;
	logic [1:0]  ctrl_q;
	logic        ovfl_q;
	logic [31:0] l1a_ext;
	logic [31:0] evt_ext;
	logic [31:0] status;

	// access phase only, no wait states
	always_comb begin
		op = chanlink_reg_pkg::op_none;
		if (psel && penable) begin
			case (paddr)
				chanlink_reg_pkg::ADDR_CTRL:
					op = pwrite ? chanlink_reg_pkg::op_wr_ctrl : chanlink_reg_pkg::op_rd_ctrl;
				chanlink_reg_pkg::ADDR_STATUS:
					op = pwrite ? chanlink_reg_pkg::op_bad : chanlink_reg_pkg::op_rd_status;
				chanlink_reg_pkg::ADDR_OVFL_CLR:
					op = pwrite ? chanlink_reg_pkg::op_clr_ovfl : chanlink_reg_pkg::op_bad;
				default:
					op = chanlink_reg_pkg::op_bad;
			endcase
		end
	end

	// status word from live buffer counts
	always_comb begin
		l1a_ext = 32'(l1a_count);
		evt_ext = 32'(evt_count);
		status = '0;
		status[chanlink_reg_pkg::STAT_L1A_LSB +: chanlink_reg_pkg::STAT_CNT_W] =
			l1a_ext[chanlink_reg_pkg::STAT_CNT_W-1:0];
		status[chanlink_reg_pkg::STAT_EVT_LSB +: chanlink_reg_pkg::STAT_CNT_W] =
			evt_ext[chanlink_reg_pkg::STAT_CNT_W-1:0];
		status[chanlink_reg_pkg::STAT_OVFL_BIT] = ovfl_q;
	end

	always_comb begin
		case (op)
			chanlink_reg_pkg::op_rd_ctrl:   prdata = 32'(ctrl_q);
			chanlink_reg_pkg::op_rd_status: prdata = status;
			default:                        prdata = '0;
		endcase
	end

	assign pslverr   = (op == chanlink_reg_pkg::op_bad);
	assign rd_enable = ctrl_q[chanlink_reg_pkg::CTRL_EN_BIT];
	assign warn      = ctrl_q[chanlink_reg_pkg::CTRL_WARN_BIT];

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			ctrl_q <= '0;
			ovfl_q <= 1'b0;
		end else begin
			if (op == chanlink_reg_pkg::op_wr_ctrl)
				ctrl_q <= pwdata[1:0];
			// a new overflow wins over a clear in the same cycle
			if (evt_ovfl)
				ovfl_q <= 1'b1;
			else if (op == chanlink_reg_pkg::op_clr_ovfl)
				ovfl_q <= 1'b0;
		end
	end

	// apb setup phase must come first
	a_apb_setup: assert property (@(posedge RCLK) disable iff (RST_RESYNC)
		penable |-> psel && $past(psel));

endmodule

//--- verilog/chanlink_sync_fifo.sv
module chanlink_sync_fifo #(
	parameter int DW = 14,
	parameter int AW = 6
) (
	input  logic          RCLK,
	input  logic          RST_RESYNC,
	input  logic [DW-1:0] din,
	input  logic          push,
	input  logic          pop,
	output logic [DW-1:0] dout,
	output logic          empty,
	output logic [AW:0]   count,
	output logic          ovfl
);

	localparam int DEPTH = 1 << AW;

	logic [DW-1:0] mem [0:DEPTH-1];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic          full;
	logic          do_push;
	logic          do_pop;

	// count reaches DEPTH only when full
	assign full    = count[AW];
	assign empty   = (count == '0);
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// head is read every cycle, so dout follows a pop by one cycle
	always_ff @(posedge RCLK) begin
		if (do_push)
			mem[wr_ptr] <= din;
		dout <= mem[rd_ptr];
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			ovfl   <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// dropped write
			ovfl <= push && full;
		end
	end

	a_no_underrun: assert property (@(posedge RCLK) disable iff (RST_RESYNC)
		pop |-> !empty);

endmodule

//--- verilog/chanlink_frame_seq.sv
module chanlink_frame_seq (
	input  logic                           RCLK,
	input  logic                           RST_RESYNC,
	input  logic                           rd_enable,
	input  logic                           evt_empty,
	input  logic                           l1a_empty,
	input  logic                           evt_end_q,
	output logic                           evt_pop,
	output logic                           l1a_pop,
	output chanlink_frame_pkg::frm_state_e word_sel,
	output logic                           word_vld
);

	chanlink_frame_pkg::frm_state_e state;
	chanlink_frame_pkg::frm_state_e state_nxt;
	logic pop_d;
	logic evt_done;

	// evt_end_q only counts if it came from a pop of this event
	assign evt_done = pop_d && evt_end_q;
	assign word_sel = state;

	always_comb begin
		state_nxt = state;
		evt_pop   = 1'b0;
		l1a_pop   = 1'b0;
		word_vld  = 1'b0;
		case (state)
			chanlink_frame_pkg::frm_idle: begin
				if (rd_enable && !l1a_empty && !evt_empty)
					state_nxt = chanlink_frame_pkg::frm_data;
			end
			chanlink_frame_pkg::frm_data: begin
				if (evt_done) begin
					state_nxt = chanlink_frame_pkg::frm_crc;
				end else if (!evt_empty) begin
					// one sample per cycle and a hold while empty
					evt_pop  = 1'b1;
					word_vld = 1'b1;
				end
			end
			chanlink_frame_pkg::frm_crc: begin
				word_vld  = 1'b1;
				state_nxt = chanlink_frame_pkg::frm_marker;
			end
			chanlink_frame_pkg::frm_marker: begin
				word_vld  = 1'b1;
				state_nxt = chanlink_frame_pkg::frm_status;
			end
			chanlink_frame_pkg::frm_status: begin
				word_vld  = 1'b1;
				state_nxt = chanlink_frame_pkg::frm_last;
			end
			chanlink_frame_pkg::frm_last: begin
				// end of the event releases its trigger
				word_vld  = 1'b1;
				l1a_pop   = 1'b1;
				state_nxt = chanlink_frame_pkg::frm_idle;
			end
			default: begin
				state_nxt = chanlink_frame_pkg::frm_idle;
			end
		endcase
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			state <= chanlink_frame_pkg::frm_idle;
			pop_d <= 1'b0;
		end else begin
			state <= state_nxt;
			pop_d <= evt_pop;
		end
	end

	// trigger released only while one is queued
	a_l1a_pop: assert property (@(posedge RCLK) disable iff (RST_RESYNC)
		l1a_pop |-> !l1a_empty);

endmodule

//--- verilog/chanlink_frame_fmt.sv
module chanlink_frame_fmt #(
	parameter int L1A_DEPTH_LOG2 = 4
) (
	input  logic                           RCLK,
	input  logic                           RST_RESYNC,
	input  chanlink_frame_pkg::frm_state_e word_sel,
	input  logic                           word_vld,
	input  logic [11:0]                    sample,
	input  logic                           ovlp_q,
	input  logic [23:0]                    l1a_num_q,
	input  logic [L1A_DEPTH_LOG2:0]        l1a_count,
	input  logic                           warn,
	output logic [15:0]                    dout,
	output logic                           dvalid,
	output logic                           last_wrd
);

	chanlink_frame_pkg::frm_state_e sel_q;
	logic        vld_q;
	logic [14:0] crc;
	logic [4:0]  queued;
	logic [15:0] frame;

	////////////////////
	// align with fifo read

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC)
			vld_q <= 1'b0;
		else
			vld_q <= word_vld;
	end

	always_ff @(posedge RCLK) begin
		sel_q <= word_sel;
	end

	////////////////////
	// crc and word select

	// crc restarts after every 7fff
	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC)
			crc <= '0;
		else if (vld_q && sel_q == chanlink_frame_pkg::frm_data)
			crc <= chanlink_frame_pkg::crc15_d13({1'b0, sample}, crc);
		else if (vld_q && sel_q == chanlink_frame_pkg::frm_last)
			crc <= '0;
	end

	// events still waiting behind the one being sent
	assign queued = 5'(l1a_count - 1'b1);

	always_comb begin
		case (sel_q)
			chanlink_frame_pkg::frm_crc:    frame = {1'b0, crc};
			chanlink_frame_pkg::frm_marker: frame = chanlink_frame_pkg::TRL_MARKER;
			chanlink_frame_pkg::frm_status: frame = {4'h7, l1a_num_q[5:0], queued, warn};
			chanlink_frame_pkg::frm_last:   frame = chanlink_frame_pkg::TRL_END;
			// data word, serial bit is always 0
			default:                        frame = {1'b0, ~ovlp_q, 2'b00, sample};
		endcase
	end

	////////////////////
	// output register

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			dvalid   <= 1'b0;
			last_wrd <= 1'b0;
		end else begin
			dvalid   <= vld_q;
			last_wrd <= vld_q && sel_q == chanlink_frame_pkg::frm_last;
		end
	end

	always_ff @(posedge RCLK) begin
		if (vld_q)
			dout <= frame;
	end

endmodule

//--- verilog/chanlink_top.sv
module chanlink_top #(
	parameter int EVT_DEPTH_LOG2 = 6,
	parameter int L1A_DEPTH_LOG2 = 4
) (
	input  logic        RCLK,
	input  logic        RST_RESYNC,
	input  logic [11:0] wdata,
	input  logic        ovlp,
	input  logic        evt_end,
	input  logic        wren,
	input  logic [23:0] l1a_num,
	input  logic        l1a_push,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [7:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pslverr,
	output logic [15:0] dout,
	output logic        dvalid,
	output logic        last_wrd
);

	// event buffer entry is {evt_end, ovlp, sample}
	logic [13:0]               evt_q;
	logic                      evt_empty;
	logic [EVT_DEPTH_LOG2:0]   evt_count;
	logic                      evt_ovfl;
	logic                      evt_pop;
	logic [23:0]               l1a_q;
	logic                      l1a_empty;
	logic [L1A_DEPTH_LOG2:0]   l1a_count;
	logic                      l1a_pop;
	logic                      rd_enable;
	logic                      warn;
	logic                      word_vld;
	chanlink_frame_pkg::frm_state_e word_sel;

	chanlink_sync_fifo #(.DW(14), .AW(EVT_DEPTH_LOG2)) evt_fifo (
		.RCLK(RCLK), .RST_RESYNC(RST_RESYNC),
		.din({evt_end, ovlp, wdata}), .push(wren), .pop(evt_pop),
		.dout(evt_q), .empty(evt_empty), .count(evt_count), .ovfl(evt_ovfl)
	);

	chanlink_sync_fifo #(.DW(24), .AW(L1A_DEPTH_LOG2)) l1a_fifo (
		.RCLK(RCLK), .RST_RESYNC(RST_RESYNC),
		.din(l1a_num), .push(l1a_push), .pop(l1a_pop),
		.dout(l1a_q), .empty(l1a_empty), .count(l1a_count), .ovfl()
	);

	chanlink_frame_seq frame_seq (
		.RCLK(RCLK), .RST_RESYNC(RST_RESYNC),
		.rd_enable(rd_enable), .evt_empty(evt_empty), .l1a_empty(l1a_empty),
		.evt_end_q(evt_q[13]), .evt_pop(evt_pop), .l1a_pop(l1a_pop),
		.word_sel(word_sel), .word_vld(word_vld)
	);

	chanlink_frame_fmt #(.L1A_DEPTH_LOG2(L1A_DEPTH_LOG2)) frame_fmt (
		.RCLK(RCLK), .RST_RESYNC(RST_RESYNC),
		.word_sel(word_sel), .word_vld(word_vld),
		.sample(evt_q[11:0]), .ovlp_q(evt_q[12]), .l1a_num_q(l1a_q),
		.l1a_count(l1a_count), .warn(warn),
		.dout(dout), .dvalid(dvalid), .last_wrd(last_wrd)
	);

	chanlink_cfg_decode #(
		.EVT_DEPTH_LOG2(EVT_DEPTH_LOG2),
		.L1A_DEPTH_LOG2(L1A_DEPTH_LOG2)
	) cfg_decode (
		.RCLK(RCLK), .RST_RESYNC(RST_RESYNC),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.l1a_count(l1a_count), .evt_count(evt_count), .evt_ovfl(evt_ovfl),
		.prdata(prdata), .pslverr(pslverr), .rd_enable(rd_enable), .warn(warn)
	);

endmodule

//--- testbench/chanlink_tb.sv
module chanlink_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int EVT_DEPTH_LOG2 = 6;
	localparam int L1A_DEPTH_LOG2 = 4;
	localparam int NROWS          = 6;
	localparam int CYCLE_LIMIT    = 40 * NROWS + 200;

	// one event per row
	typedef struct packed {
		int          n;
		logic [11:0] first;
		logic [11:0] incr;
		logic [15:0] ovlp;
		logic [23:0] l1a;
		logic        chain;
		logic        warn;
		logic        rnd;
	} row_t;

	logic        RCLK;
	logic        RST_RESYNC;
	logic [11:0] wdata;
	logic        ovlp;
	logic        evt_end;
	logic        wren;
	logic [23:0] l1a_num;
	logic        l1a_push;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pslverr;
	logic [15:0] dout;
	logic        dvalid;
	logic        last_wrd;

	row_t        tbl [NROWS];
	string       names [NROWS];
	logic [16:0] exp_q [$];
	logic [16:0] got_q [$];
	integer      seed;
	int          cycles;
	int          tests;
	int          checks;
	int          errors;
	int          test_err0;

	chanlink_top #(
		.EVT_DEPTH_LOG2(EVT_DEPTH_LOG2),
		.L1A_DEPTH_LOG2(L1A_DEPTH_LOG2)
	) dut (
		.RCLK(RCLK), .RST_RESYNC(RST_RESYNC),
		.wdata(wdata), .ovlp(ovlp), .evt_end(evt_end), .wren(wren),
		.l1a_num(l1a_num), .l1a_push(l1a_push),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pslverr(pslverr),
		.dout(dout), .dvalid(dvalid), .last_wrd(last_wrd)
	);

	initial begin
		RCLK = 1'b0;
		forever #50 RCLK = ~RCLK;
	end

	// frame words with last_wrd in bit 16
	always @(negedge RCLK) begin
		if (dvalid)
			got_q.push_back({last_wrd, dout});
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge RCLK);
			cycles++;
		end
		$display("timeout after %0d cycles, the frames did not complete", cycles);
		$display("Test failed");
		$finish;
	end

	task automatic load_table();
		tbl[0] = '{4, 12'h123, 12'h011, 16'h0005, 24'h000a15, 1'b0, 1'b0, 1'b0};
		tbl[1] = '{6, 12'hffe, 12'h001, 16'h0024, 24'h123427, 1'b0, 1'b0, 1'b0};
		tbl[2] = '{3, 12'h800, 12'h100, 16'h0000, 24'h00003f, 1'b1, 1'b0, 1'b0};
		tbl[3] = '{5, 12'h055, 12'h0aa, 16'h001f, 24'hfedc01, 1'b0, 1'b0, 1'b0};
		tbl[4] = '{3, 12'h000, 12'h000, 16'h0002, 24'h000080, 1'b0, 1'b1, 1'b1};
		tbl[5] = '{1, 12'h000, 12'h000, 16'h0001, 24'h000002, 1'b0, 1'b0, 1'b0};
		names[0] = "readout disabled";
		names[1] = "single event";
		names[2] = "two queued events";
		names[3] = "second queued event";
		names[4] = "warn bit";
		names[5] = "one sample event";
	endtask

	task automatic next_cycle();
		@(posedge RCLK);
		#10;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic end_test(input string name);
		if (errors == test_err0)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errors - test_err0);
	endtask

	////////////////////
	// apb access

	// two-cycle access that starts and ends 10 ns after an edge
	task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wd,
		output logic [31:0] rd, output logic err);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wd;
		next_cycle();
		penable = 1'b1;
		@(negedge RCLK);
		rd  = prdata;
		err = pslverr;
		next_cycle();
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] wd, input logic exp_err);
		logic [31:0] rd;
		logic        err;
		apb_access(1'b1, addr, wd, rd, err);
		check_value("pslverr", 32'(err), 32'(exp_err));
	endtask

	task automatic apb_read(input logic [7:0] addr, input logic [31:0] exp, input logic exp_err);
		logic [31:0] rd;
		logic        err;
		apb_access(1'b0, addr, 32'd0, rd, err);
		check_value("prdata", rd, exp);
		check_value("pslverr", 32'(err), 32'(exp_err));
	endtask

	////////////////////
	// events and reference model

	// drives one event and queues the frame it should produce
	task automatic write_event(input int r, input int queued, input logic warn_b);
		logic [11:0] s;
		logic [15:0] pat;
		logic [14:0] crc;
		crc = '0;
		s   = tbl[r].first;
		pat = tbl[r].ovlp;
		for (int i = 0; i < tbl[r].n; i++) begin
			if (tbl[r].rnd)
				s = 12'($random(seed));
			wdata   = s;
			ovlp    = pat[0];
			evt_end = (i == tbl[r].n - 1);
			wren    = 1'b1;
			exp_q.push_back({1'b0, 1'b0, ~pat[0], 2'b00, s});
			crc = chanlink_frame_pkg::crc15_d13({1'b0, s}, crc);
			next_cycle();
			s   = s + tbl[r].incr;
			pat = pat >> 1;
		end
		wren     = 1'b0;
		evt_end  = 1'b0;
		ovlp     = 1'b0;
		l1a_num  = tbl[r].l1a;
		l1a_push = 1'b1;
		next_cycle();
		l1a_push = 1'b0;
		exp_q.push_back({1'b0, 1'b0, crc});
		exp_q.push_back({1'b0, chanlink_frame_pkg::TRL_MARKER});
		exp_q.push_back({1'b0, 4'h7, tbl[r].l1a[5:0], 5'(queued), warn_b});
		exp_q.push_back({1'b1, chanlink_frame_pkg::TRL_END});
	endtask

	task automatic compare_frames();
		check_value("frame word count", 32'(got_q.size()), 32'(exp_q.size()));
		for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
			check_value($sformatf("dout[%0d]", i), 32'(got_q[i][15:0]), 32'(exp_q[i][15:0]));
			check_value($sformatf("last_wrd[%0d]", i), 32'(got_q[i][16]), 32'(exp_q[i][16]));
		end
		got_q.delete();
		exp_q.delete();
	endtask

	// queue k rows with readout off before enabling and collecting
	task automatic run_group(input int r, input int k);
		int          total;
		logic        warn_b;
		logic [31:0] st;
		total     = 0;
		warn_b    = tbl[r].warn;
		test_err0 = errors;
		tests++;
		for (int j = 0; j < k; j++) begin
			write_event(r + j, k - 1 - j, warn_b);
			total += tbl[r + j].n;
		end
		repeat (6) next_cycle();
		checks++;
		if (got_q.size() != 0) begin
			errors++;
			$display("frame words came out at %0t ns while readout was disabled", $time);
		end
		st       = '0;
		st[4:0]  = 5'(k);
		st[12:8] = 5'(total);
		apb_read(chanlink_reg_pkg::ADDR_STATUS, st, 1'b0);
		apb_write(chanlink_reg_pkg::ADDR_CTRL, {30'd0, warn_b, 1'b1}, 1'b0);
		while (got_q.size() < exp_q.size())
			next_cycle();
		repeat (3) next_cycle();
		compare_frames();
		apb_write(chanlink_reg_pkg::ADDR_CTRL, 32'd0, 1'b0);
		end_test(names[r]);
	endtask

	initial begin
		int          r;
		int          k;
		logic [31:0] st;
		RST_RESYNC = 1'b1;
		wdata      = '0;
		ovlp       = 1'b0;
		evt_end    = 1'b0;
		wren       = 1'b0;
		l1a_num    = '0;
		l1a_push   = 1'b0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		seed       = 32'h18ee280f;
		tests      = 0;
		checks     = 0;
		errors     = 0;
		load_table();
		repeat (8) @(posedge RCLK);
		#10 RST_RESYNC = 1'b0;
		next_cycle();

		test_err0 = errors;
		tests++;
		check_value("dvalid", 32'(dvalid), 32'd0);
		check_value("last_wrd", 32'(last_wrd), 32'd0);
		check_value("pslverr", 32'(pslverr), 32'd0);
		apb_read(chanlink_reg_pkg::ADDR_CTRL, 32'd0, 1'b0);
		apb_read(chanlink_reg_pkg::ADDR_STATUS, 32'd0, 1'b0);
		end_test("reset values");

		r = 0;
		while (r < NROWS) begin
			k = 1;
			while (tbl[r + k - 1].chain)
				k++;
			run_group(r, k);
			r += k;
		end

		////////////////////
		// registers, bad address, overflow
		test_err0 = errors;
		tests++;
		apb_read(8'h0c, 32'd0, 1'b1);
		apb_write(8'h0c, 32'h1234, 1'b1);
		apb_write(chanlink_reg_pkg::ADDR_CTRL, 32'd2, 1'b0);
		apb_read(chanlink_reg_pkg::ADDR_CTRL, 32'd2, 1'b0);
		// readout on with no trigger queued
		apb_write(chanlink_reg_pkg::ADDR_CTRL, 32'd1, 1'b0);
		// one push more than the event buffer holds
		for (int i = 0; i < (1 << EVT_DEPTH_LOG2) + 1; i++) begin
			wdata = 12'($random(seed));
			ovlp  = wdata[0];
			wren  = 1'b1;
			next_cycle();
		end
		wren = 1'b0;
		next_cycle();
		st       = '0;
		st[12:8] = 5'(1 << EVT_DEPTH_LOG2);
		st[16]   = 1'b1;
		apb_read(chanlink_reg_pkg::ADDR_STATUS, st, 1'b0);
		apb_write(chanlink_reg_pkg::ADDR_OVFL_CLR, 32'd0, 1'b0);
		st[16] = 1'b0;
		apb_read(chanlink_reg_pkg::ADDR_STATUS, st, 1'b0);
		check_value("frame word count", 32'(got_q.size()), 32'd0);
		end_test("registers and errors");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- files.f
verilog/chanlink_frame_pkg.sv
verilog/chanlink_reg_pkg.sv
verilog/chanlink_cfg_decode.sv
verilog/chanlink_sync_fifo.sv
verilog/chanlink_frame_seq.sv
verilog/chanlink_frame_fmt.sv
verilog/chanlink_top.sv
testbench/chanlink_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the chanlink testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module chanlink_tb -f files.f \
	-Mdir obj_dir -o chanlink_sim > build.log 2>&1 \
	&& ./obj_dir/chanlink_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -qx "Test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
